/* apg_params.svh */
/*
 * Pattern generator build parameters
 * Sample width, buffer depth and synchronizer length
 */
`ifndef APG_PARAMS_SVH
`define APG_PARAMS_SVH

// Signals per sample, one bit per output pin
`define APG_NUM_SIG 14

// Depth of both the write buffer and the read buffer
`define APG_NUM_SAMP 128

// Flops in every clock-crossing synchronizer, at least 2
`define APG_SYNC_STAGES 3

`endif

/* apg_state_pkg.sv */
/*
 * Generator state encoding and status register layout
 */
package apg_state_pkg;

   // Wave-domain FSM states, code 3 is never entered
   typedef enum logic [1:0] {
      ST_IDLE        = 2'd0,
      ST_TRANSACTION = 2'd1,
      ST_DONE        = 2'd2
   } apg_state_e;

   // Status word is {triggered, state}
   localparam int STATUS_W         = 3;
   localparam int STATUS_STATE_LSB = 0;
   localparam int STATUS_TRIG_BIT  = 2;

endpackage

/* apg_reg_pkg.sv */
/*
 * Host register map of the pattern generator
 * Address codes and control register bit positions
 */
package apg_reg_pkg;

   typedef enum logic [3:0] {
      REG_RUN           = 4'd0,
      REG_CLEAR         = 4'd1,
      REG_CONTROL       = 4'd2,
      REG_N_SAMPLES     = 4'd3,
      REG_DEFAULTS      = 4'd4,
      REG_WRITE_CHANNEL = 4'd5,
      REG_READ_CHANNEL  = 4'd6,
      REG_SAMPLE_COUNT  = 4'd7,
      REG_STATUS        = 4'd8,
      REG_DBG_ERROR     = 4'd9,
      REG_WRITE_LEN     = 4'd10,
      REG_READ_PTR      = 4'd11,
      REG_WAVE_PTR      = 4'd12
   } apg_reg_e;

   // Control register, only the loop flag is defined so far
   localparam int CTRL_W        = 8;
   localparam int CTRL_LOOP_BIT = 0;

endpackage

/* bit_sync.sv */
/*
 * Single-bit synchronizer
 * Carries a slow level into the destination clock through a flop chain
 */
`include "apg_params.svh"

module bit_sync (
   input  logic dest_clk,
   input  logic dest_resetn,
   input  logic src_in,
   output logic dest_out
);

   // First stage may go metastable, later stages let it settle
   logic [`APG_SYNC_STAGES-1:0] sync_q;

   always_ff @(posedge dest_clk or negedge dest_resetn) begin
      if (!dest_resetn) begin
         sync_q <= '0;
      end else begin
         sync_q <= {sync_q[`APG_SYNC_STAGES-2:0], src_in};
      end
   end

   assign dest_out = sync_q[`APG_SYNC_STAGES-1];

   // Source level has to outlast the chain, a shorter pulse is lost or mangled
   a_src_held: assert property (@(posedge dest_clk) disable iff (!dest_resetn)
      $changed(dest_out) |-> $past(src_in, 1) == dest_out);

endmodule

/* glitchless_state_cdc.sv */
/*
 * Glitch-free crossing of the generator state
 * State is sent one-hot so bit skew only yields invalid codes, which are ignored
 */
module glitchless_state_cdc (
   input  logic                      src_clk,
   input  apg_state_pkg::apg_state_e src_in,
   input  logic                      dest_clk,
   input  logic                      dest_resetn,
   output apg_state_pkg::apg_state_e dest_out
);
   import apg_state_pkg::*;

   logic [3:0] src_enc;
   logic [3:0] src_enc_q;
   logic [3:0] dest_enc;

   // One-hot encode in the source domain
   always_comb begin
      case (src_in)
         ST_IDLE:        src_enc = 4'b0001;
         ST_TRANSACTION: src_enc = 4'b0010;
         ST_DONE:        src_enc = 4'b0100;
         default:        src_enc = 4'b1000;
      endcase
   end

   // Registered so no combinational logic feeds the synchronizers
   always_ff @(posedge src_clk) begin
      src_enc_q <= src_enc;
   end

   for (genvar i = 0; i < 4; i++) begin : g_sync
      bit_sync u_sync (
         .dest_clk   (dest_clk),
         .dest_resetn(dest_resetn),
         .src_in     (src_enc_q[i]),
         .dest_out   (dest_enc[i])
      );
   end

   // Only a clean one-hot code moves the output, anything else holds
   always_ff @(posedge dest_clk or negedge dest_resetn) begin
      if (!dest_resetn) begin
         dest_out <= ST_IDLE;
      end else begin
         case (dest_enc)
            4'b0001: dest_out <= ST_IDLE;
            4'b0010: dest_out <= ST_TRANSACTION;
            4'b0100: dest_out <= ST_DONE;
            4'b1000: dest_out <= apg_state_e'(2'd3);
            default: dest_out <= dest_out;
         endcase
      end
   end

   a_enc_onehot: assert property (@(posedge src_clk) disable iff (!dest_resetn)
      $onehot(src_enc_q));

endmodule

/* apg_reg_file.sv */
/*
 * Host register file of the pattern generator
 * Holds configuration, turns writes into pulses and muxes status onto read data
 */
`include "apg_params.svh"

module apg_reg_file (
   input  logic                                axi_clk,
   input  logic                                axi_resetn,
   input  logic                                reg_wr,
   input  logic                                reg_rd,
   input  apg_reg_pkg::apg_reg_e               reg_addr,
   input  logic [31:0]                         reg_wdata,
   output logic [31:0]                         reg_rdata,
   output logic                                run,
   output logic                                clear,
   output logic [apg_reg_pkg::CTRL_W-1:0]      control,
   output logic [31:0]                         n_samples,
   output logic [`APG_NUM_SIG-1:0]             write_defaults,
   output logic [`APG_NUM_SIG-1:0]             write_channel,
   output logic                                write_channel_wr_strobe,
   output logic                                read_channel_rd_strobe,
   input  logic [`APG_NUM_SIG-1:0]             read_channel,
   input  logic [31:0]                         sample_count,
   input  logic [apg_state_pkg::STATUS_W-1:0]  status,
   input  logic [31:0]                         dbg_error,
   input  logic [31:0]                         write_buffer_len,
   input  logic [31:0]                         next_read_sample,
   input  logic [31:0]                         wave_ptr
);
   import apg_reg_pkg::*;

   logic [31:0] rd_mux;

   // Configuration levels and single-cycle command pulses
   always_ff @(posedge axi_clk or negedge axi_resetn) begin
      if (!axi_resetn) begin
         run                     <= 1'b0;
         clear                   <= 1'b0;
         write_channel_wr_strobe <= 1'b0;
         control                 <= '0;
         n_samples               <= '0;
         write_defaults          <= '0;
      end else begin
         // Pulses drop again unless this cycle re-arms them
         run                     <= 1'b0;
         clear                   <= 1'b0;
         write_channel_wr_strobe <= 1'b0;
         if (reg_wr) begin
            case (reg_addr)
               REG_RUN:           run <= 1'b1;
               REG_CLEAR:         clear <= 1'b1;
               REG_CONTROL:       control <= reg_wdata[CTRL_W-1:0];
               REG_N_SAMPLES:     n_samples <= reg_wdata;
               REG_DEFAULTS:      write_defaults <= reg_wdata[`APG_NUM_SIG-1:0];
               REG_WRITE_CHANNEL: write_channel_wr_strobe <= 1'b1;
               default:           ;
            endcase
         end
      end
   end

   // Write data stays valid while the generator delays the strobe
   always_ff @(posedge axi_clk) begin
      if (reg_wr && reg_addr == REG_WRITE_CHANNEL) begin
         write_channel <= reg_wdata[`APG_NUM_SIG-1:0];
      end
   end

   // Same-cycle strobe, the generator advances after this read is captured
   assign read_channel_rd_strobe = reg_rd && (reg_addr == REG_READ_CHANNEL);

   // Readback, write-only addresses return zero
   always_comb begin
      case (reg_addr)
         REG_CONTROL:      rd_mux = 32'(control);
         REG_N_SAMPLES:    rd_mux = n_samples;
         REG_DEFAULTS:     rd_mux = 32'(write_defaults);
         REG_READ_CHANNEL: rd_mux = 32'(read_channel);
         REG_SAMPLE_COUNT: rd_mux = sample_count;
         REG_STATUS:       rd_mux = 32'(status);
         REG_DBG_ERROR:    rd_mux = dbg_error;
         REG_WRITE_LEN:    rd_mux = write_buffer_len;
         REG_READ_PTR:     rd_mux = next_read_sample;
         REG_WAVE_PTR:     rd_mux = wave_ptr;
         default:          rd_mux = '0;
      endcase
   end

   always_ff @(posedge axi_clk or negedge axi_resetn) begin
      if (!axi_resetn) begin
         reg_rdata <= '0;
      end else if (reg_rd) begin
         reg_rdata <= rd_mux;
      end
   end

   // Host issues one access per cycle
   a_no_wr_rd: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
      !(reg_wr && reg_rd));

endmodule

/* arbitrary_pattern_generator.sv */
/*
 * Arbitrary pattern generator core
 * Host fills a write buffer, wave_clk plays it out and captures inputs
 * into a read buffer, which the host then reads back sample by sample
 */
`include "apg_params.svh"

module arbitrary_pattern_generator (
   input  logic                                wave_clk,
   input  logic                                axi_clk,
   input  logic                                axi_resetn,
   input  logic                                run,
   input  logic                                clear,
   input  logic [apg_reg_pkg::CTRL_W-1:0]      control,
   input  logic [31:0]                         n_samples,
   input  logic [`APG_NUM_SIG-1:0]             write_defaults,
   input  logic [`APG_NUM_SIG-1:0]             write_channel,
   input  logic                                write_channel_wr_strobe,
   input  logic                                read_channel_rd_strobe,
   output logic [`APG_NUM_SIG-1:0]             read_channel,
   output logic [31:0]                         sample_count,
   output logic [apg_state_pkg::STATUS_W-1:0]  status,
   output logic [31:0]                         dbg_error,
   output logic [31:0]                         write_buffer_len,
   output logic [31:0]                         next_read_sample,
   output logic [31:0]                         wave_ptr,
   output logic [`APG_NUM_SIG-1:0]             output_signals,
   input  logic [`APG_NUM_SIG-1:0]             input_signals
);
   import apg_state_pkg::*;
   import apg_reg_pkg::*;

   localparam int          IDX_W    = $clog2(`APG_NUM_SAMP);
   localparam logic [31:0] NUM_SAMP = 32'(`APG_NUM_SAMP);

   // Write buffer is filled by the host, read buffer by the wave domain
   logic [`APG_NUM_SIG-1:0] write_buffer [`APG_NUM_SAMP];
   logic [`APG_NUM_SIG-1:0] read_buffer  [`APG_NUM_SAMP];

   apg_state_e              state;
   apg_state_e              state_axi;
   logic [31:0]             n_samples_int;
   logic                    loop;
   logic                    triggered;
   logic                    triggered_wave;
   logic                    wave_resetn;
   logic                    wr_q1;
   logic                    wr_q2;
   logic                    rd_q1;
   logic                    rd_q2;
   logic                    double_wr;
   logic                    double_rd;
   logic                    wr_accept;
   logic                    rd_accept;
   logic [`APG_NUM_SIG-1:0] rd_sample;
   logic                    last_sample;
   logic                    cap_valid;
   logic [IDX_W-1:0]        cap_ptr;

   // Shot length never exceeds the buffer
   always_comb begin
      if (n_samples > NUM_SAMP) begin
         n_samples_int = NUM_SAMP;
      end else begin
         n_samples_int = n_samples;
      end
   end

   always_comb begin
      status                                         = '0;
      status[STATUS_TRIG_BIT]                        = triggered;
      status[STATUS_STATE_LSB +: $bits(apg_state_e)] = state_axi;
   end

   // Run pulse latched until the wave domain reports DONE
   always_ff @(posedge axi_clk or negedge axi_resetn) begin
      if (!axi_resetn) begin
         triggered <= 1'b0;
      end else if (run) begin
         triggered <= 1'b1;
      end else if (state_axi == ST_DONE) begin
         triggered <= 1'b0;
      end
   end

   // Two strobes in a row point to a host fault
   assign double_wr = wr_q1 && wr_q2;
   assign double_rd = rd_q1 && rd_q2;

   // Write uses the delayed strobe so write_channel has settled
   assign wr_accept = wr_q1 && !wr_q2 && !clear && (state_axi != ST_DONE)
                      && (write_buffer_len < NUM_SAMP);
   assign rd_accept = read_channel_rd_strobe && !rd_q1 && !clear && (state_axi != ST_DONE);

   // Past the last captured slot the read channel returns zero
   assign rd_sample = (next_read_sample < NUM_SAMP) ?
                      read_buffer[next_read_sample[IDX_W-1:0]] : '0;

   // Host side of both buffers
   always_ff @(posedge axi_clk or negedge axi_resetn) begin
      if (!axi_resetn) begin
         wr_q1            <= 1'b0;
         wr_q2            <= 1'b0;
         rd_q1            <= 1'b0;
         rd_q2            <= 1'b0;
         dbg_error        <= '0;
         write_buffer_len <= '0;
         next_read_sample <= 32'd1;
         read_channel     <= '0;
      end else begin
         wr_q1 <= write_channel_wr_strobe;
         wr_q2 <= wr_q1;
         rd_q1 <= read_channel_rd_strobe;
         rd_q2 <= rd_q1;
         if (clear) begin
            write_buffer_len <= '0;
            next_read_sample <= 32'd1;
            read_channel     <= '0;
            dbg_error        <= '0;
         end else begin
            dbg_error <= dbg_error | {30'd0, double_rd, double_wr};
            if (state_axi == ST_DONE) begin
               // Run finished, rewind for new data and present sample 0
               write_buffer_len <= '0;
               next_read_sample <= 32'd1;
               read_channel     <= read_buffer[0];
            end else begin
               if (wr_accept) begin
                  write_buffer_len <= write_buffer_len + 32'd1;
               end
               if (rd_accept) begin
                  read_channel <= rd_sample;
                  if (next_read_sample < NUM_SAMP) begin
                     next_read_sample <= next_read_sample + 32'd1;
                  end
               end
            end
         end
      end
   end

   always_ff @(posedge axi_clk) begin
      if (wr_accept) begin
         write_buffer[write_buffer_len[IDX_W-1:0]] <= write_channel;
      end
   end

   // Wave reset asserts with axi_resetn, releases on wave_clk
   bit_sync u_wave_rst_sync (
      .dest_clk   (wave_clk),
      .dest_resetn(axi_resetn),
      .src_in     (1'b1),
      .dest_out   (wave_resetn)
   );

   bit_sync u_trig_sync (
      .dest_clk   (wave_clk),
      .dest_resetn(wave_resetn),
      .src_in     (triggered),
      .dest_out   (triggered_wave)
   );

   glitchless_state_cdc u_state_cdc (
      .src_clk    (wave_clk),
      .src_in     (state),
      .dest_clk   (axi_clk),
      .dest_resetn(axi_resetn),
      .dest_out   (state_axi)
   );

   // Control and buffers are only changed by the host while idle
   assign loop        = control[CTRL_LOOP_BIT];
   assign last_sample = (wave_ptr + 32'd1) >= n_samples_int;

   // Wave FSM, DONE holds until the trigger drop comes back
   always_ff @(posedge wave_clk or negedge wave_resetn) begin
      if (!wave_resetn) begin
         state        <= ST_IDLE;
         wave_ptr     <= '0;
         sample_count <= '0;
         cap_valid    <= 1'b0;
      end else begin
         cap_valid <= (state == ST_TRANSACTION);
         case (state)
            ST_IDLE: begin
               if (triggered_wave) begin
                  state <= ST_TRANSACTION;
               end
            end
            ST_TRANSACTION: begin
               if (!triggered_wave) begin
                  state <= ST_IDLE;
               end else if (!loop && last_sample) begin
                  state <= ST_DONE;
               end
            end
            default: begin
               if (!triggered_wave) begin
                  state <= ST_IDLE;
               end
            end
         endcase
         // One sample per cycle, pointer wraps for loop mode
         if (state == ST_TRANSACTION) begin
            sample_count <= sample_count + 32'd1;
            if (last_sample) begin
               wave_ptr <= '0;
            end else begin
               wave_ptr <= wave_ptr + 32'd1;
            end
         end else begin
            wave_ptr <= '0;
         end
      end
   end

   // Playback, and capture one cycle later so input lands at the index it answers
   always_ff @(posedge wave_clk) begin
      if (state == ST_TRANSACTION) begin
         output_signals <= write_buffer[wave_ptr[IDX_W-1:0]];
      end else begin
         output_signals <= write_defaults;
      end
      cap_ptr <= wave_ptr[IDX_W-1:0];
      if (cap_valid) begin
         read_buffer[cap_ptr] <= input_signals;
      end
   end

   a_len_bound: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
      write_buffer_len <= NUM_SAMP);

endmodule

/* apg_top.sv */
/*
 * Pattern generator top level
 * Register file on the host side, generator core behind it
 */
`include "apg_params.svh"

module apg_top (
   input  logic                    axi_clk,
   input  logic                    axi_resetn,
   input  logic                    wave_clk,
   input  logic                    reg_wr,
   input  logic                    reg_rd,
   input  apg_reg_pkg::apg_reg_e   reg_addr,
   input  logic [31:0]             reg_wdata,
   output logic [31:0]             reg_rdata,
   output logic [`APG_NUM_SIG-1:0] output_signals,
   input  logic [`APG_NUM_SIG-1:0] input_signals
);
   import apg_state_pkg::*;
   import apg_reg_pkg::*;

   // Register file to core
   logic                    run;
   logic                    clear;
   logic [CTRL_W-1:0]       control;
   logic [31:0]             n_samples;
   logic [`APG_NUM_SIG-1:0] write_defaults;
   logic [`APG_NUM_SIG-1:0] write_channel;
   logic                    write_channel_wr_strobe;
   logic                    read_channel_rd_strobe;

   // Core status back to the host
   logic [`APG_NUM_SIG-1:0] read_channel;
   logic [31:0]             sample_count;
   logic [STATUS_W-1:0]     status;
   logic [31:0]             dbg_error;
   logic [31:0]             write_buffer_len;
   logic [31:0]             next_read_sample;
   logic [31:0]             wave_ptr;

   apg_reg_file u_reg_file (.*);

   arbitrary_pattern_generator u_apg (.*);

endmodule

/* apg_tb.sv */
/*
 * Testbench for the pattern generator top level
 * Register operations come from a table, outputs loop back to inputs through a mask
 */
`include "apg_params.svh"

module apg_tb;
   timeunit 1ns;
   timeprecision 1ps;

   import apg_state_pkg::*;
   import apg_reg_pkg::*;

   typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_WAIT, OP_OUT, OP_DOUBLE_WRITE} tb_op_e;

   localparam logic [`APG_NUM_SIG-1:0] LOOP_MASK = `APG_NUM_SIG'(32'h15a5);
   localparam int NUM_SAMP   = `APG_NUM_SAMP;
   // Status polls per wait, one poll is three axi_clk cycles
   localparam int WAIT_POLLS = 400;

   logic                    axi_clk;
   logic                    axi_resetn;
   logic                    wave_clk;
   logic                    reg_wr;
   logic                    reg_rd;
   apg_reg_e                reg_addr;
   logic [31:0]             reg_wdata;
   logic [31:0]             reg_rdata;
   logic [`APG_NUM_SIG-1:0] output_signals;
   logic [`APG_NUM_SIG-1:0] input_signals;

   // Stimulus table, one entry per row in every queue
   tb_op_e      op_q [$];
   apg_reg_e    addr_q [$];
   logic [31:0] data_q [$];
   logic [31:0] exp_q [$];
   string       name_q [$];

   logic [31:0]             lcg_state;
   logic [`APG_NUM_SIG-1:0] one_shot [16];
   logic [`APG_NUM_SIG-1:0] long_shot [NUM_SAMP+5];
   logic [`APG_NUM_SIG-1:0] idle_value;
   logic [31:0]             exp_count;
   int                      check_count;
   int                      error_count;
   int                      timeout_count;

   apg_top dut (
      .axi_clk       (axi_clk),
      .axi_resetn    (axi_resetn),
      .wave_clk      (wave_clk),
      .reg_wr        (reg_wr),
      .reg_rd        (reg_rd),
      .reg_addr      (reg_addr),
      .reg_wdata     (reg_wdata),
      .reg_rdata     (reg_rdata),
      .output_signals(output_signals),
      .input_signals (input_signals)
   );

   // Host clock 40 ns, wave clock 100 ns, their rising edges never meet
   initial axi_clk = 1'b0;
   always #20 axi_clk = ~axi_clk;
   initial wave_clk = 1'b0;
   always #50 wave_clk = ~wave_clk;

   // Loopback so each captured sample is the played one XOR the mask
   assign input_signals = output_signals ^ LOOP_MASK;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic add_row(input tb_op_e op, input apg_reg_e addr, input logic [31:0] data,
                          input logic [31:0] exp, input string name);
      op_q.push_back(op);
      addr_q.push_back(addr);
      data_q.push_back(data);
      exp_q.push_back(exp);
      name_q.push_back(name);
   endtask

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      check_count++;
      if (act !== exp) begin
         error_count++;
         $display("Mismatch %s expected 0x%08h actual 0x%08h", name, exp, act);
      end
   endtask

   // One-cycle strobe then an idle cycle, so the core debounce accepts every access
   task automatic reg_write(input apg_reg_e addr, input logic [31:0] data);
      @(posedge axi_clk);
      reg_wr    <= 1'b1;
      reg_addr  <= addr;
      reg_wdata <= data;
      @(posedge axi_clk);
      reg_wr <= 1'b0;
      @(posedge axi_clk);
   endtask

   // Strobe held for two cycles, the core sees it as a double strobe
   task automatic reg_double_write(input apg_reg_e addr, input logic [31:0] data);
      @(posedge axi_clk);
      reg_wr    <= 1'b1;
      reg_addr  <= addr;
      reg_wdata <= data;
      repeat (2) @(posedge axi_clk);
      reg_wr <= 1'b0;
      repeat (2) @(posedge axi_clk);
   endtask

   // Read data is registered, it is stable one edge after the strobe drops
   task automatic reg_read(input apg_reg_e addr, output logic [31:0] data);
      @(posedge axi_clk);
      reg_rd   <= 1'b1;
      reg_addr <= addr;
      @(posedge axi_clk);
      reg_rd <= 1'b0;
      @(posedge axi_clk);
      data = reg_rdata;
   endtask

   task automatic wait_state(input logic [1:0] st, input string name);
      logic [31:0] value;
      int          polls;
      polls = 0;
      reg_read(REG_STATUS, value);
      while (value[STATUS_STATE_LSB +: 2] != st && polls < WAIT_POLLS) begin
         reg_read(REG_STATUS, value);
         polls++;
      end
      if (value[STATUS_STATE_LSB +: 2] != st) begin
         timeout_count++;
         $display("Timeout in %s, state %0d never showed on the status register", name, st);
      end
   endtask

   // Give write_defaults time to reach the wave-domain output flops
   task automatic check_output(input logic [31:0] exp, input string name);
      repeat (8) @(posedge axi_clk);
      check_value(name, exp, 32'(output_signals));
   endtask

   task automatic build_table();
      lcg_state = 32'h9ec9_4bdf;
      // Idle output follows the defaults
      lcg_state  = lcg_next(lcg_state);
      idle_value = lcg_state[31 -: `APG_NUM_SIG];
      add_row(OP_READ, REG_STATUS, 0, 32'(ST_IDLE), "idle_status_reset");
      add_row(OP_OUT, REG_STATUS, 0, 0, "idle_out_reset");
      add_row(OP_WRITE, REG_DEFAULTS, 32'(idle_value), 0, "idle_defaults_wr");
      add_row(OP_OUT, REG_STATUS, 0, 32'(idle_value), "idle_out_defaults");
      add_row(OP_READ, REG_STATUS, 0, 32'(ST_IDLE), "idle_status_defaults");
      add_row(OP_READ, REG_DEFAULTS, 0, 32'(idle_value), "idle_defaults_rd");
      add_row(OP_READ, REG_SAMPLE_COUNT, 0, exp_count, "idle_count");
      // One-shot run of 16 samples
      for (int i = 0; i < 16; i++) begin
         lcg_state   = lcg_next(lcg_state);
         one_shot[i] = lcg_state[31 -: `APG_NUM_SIG];
         add_row(OP_WRITE, REG_WRITE_CHANNEL, 32'(one_shot[i]), 0, "shot_fill");
      end
      add_row(OP_READ, REG_WRITE_LEN, 0, 16, "shot_len");
      add_row(OP_WRITE, REG_N_SAMPLES, 16, 0, "shot_n");
      add_row(OP_WRITE, REG_CONTROL, 0, 0, "shot_ctrl");
      add_row(OP_WRITE, REG_RUN, 1, 0, "shot_run");
      add_row(OP_WAIT, REG_STATUS, 0, 32'(ST_DONE), "shot_done");
      add_row(OP_WAIT, REG_STATUS, 0, 32'(ST_IDLE), "shot_idle");
      add_row(OP_READ, REG_STATUS, 0, 32'(ST_IDLE), "shot_status");
      for (int i = 0; i < 16; i++) begin
         add_row(OP_READ, REG_READ_CHANNEL, 0, 32'(one_shot[i] ^ LOOP_MASK), "shot_capture");
      end
      exp_count = exp_count + 16;
      add_row(OP_READ, REG_SAMPLE_COUNT, 0, exp_count, "shot_count");
      add_row(OP_READ, REG_WRITE_LEN, 0, 0, "shot_len_rewind");
      // Overfilled buffer and an oversized shot length
      for (int i = 0; i < NUM_SAMP + 5; i++) begin
         lcg_state    = lcg_next(lcg_state);
         long_shot[i] = lcg_state[31 -: `APG_NUM_SIG];
         add_row(OP_WRITE, REG_WRITE_CHANNEL, 32'(long_shot[i]), 0, "clamp_fill");
      end
      add_row(OP_READ, REG_WRITE_LEN, 0, NUM_SAMP, "clamp_len");
      add_row(OP_WRITE, REG_N_SAMPLES, 1000, 0, "clamp_n");
      add_row(OP_WRITE, REG_RUN, 1, 0, "clamp_run");
      add_row(OP_WAIT, REG_STATUS, 0, 32'(ST_DONE), "clamp_done");
      add_row(OP_WAIT, REG_STATUS, 0, 32'(ST_IDLE), "clamp_idle");
      exp_count = exp_count + NUM_SAMP;
      add_row(OP_READ, REG_SAMPLE_COUNT, 0, exp_count, "clamp_count");
      for (int i = 0; i < 4; i++) begin
         add_row(OP_READ, REG_READ_CHANNEL, 0, 32'(long_shot[i] ^ LOOP_MASK), "clamp_capture");
      end
      // Loop mode, polls span more than one full pass of the buffer
      add_row(OP_WRITE, REG_CONTROL, 1 << CTRL_LOOP_BIT, 0, "loop_ctrl");
      add_row(OP_WRITE, REG_RUN, 1, 0, "loop_run");
      add_row(OP_WAIT, REG_STATUS, 0, 32'(ST_TRANSACTION), "loop_start");
      for (int i = 0; i < 120; i++) begin
         add_row(OP_READ, REG_STATUS, 0, (1 << STATUS_TRIG_BIT) | 32'(ST_TRANSACTION),
                 "loop_busy");
      end
      add_row(OP_WRITE, REG_CONTROL, 0, 0, "loop_stop");
      add_row(OP_WAIT, REG_STATUS, 0, 32'(ST_DONE), "loop_done");
      add_row(OP_WAIT, REG_STATUS, 0, 32'(ST_IDLE), "loop_idle");
      // Clear after some writes and reads, read buffer still holds the long shot
      for (int i = 0; i < 3; i++) begin
         lcg_state = lcg_next(lcg_state);
         add_row(OP_WRITE, REG_WRITE_CHANNEL, 32'(lcg_state[31 -: `APG_NUM_SIG]), 0,
                 "clear_fill");
      end
      // Held strobe stores one sample and raises the write flag
      lcg_state = lcg_next(lcg_state);
      add_row(OP_DOUBLE_WRITE, REG_WRITE_CHANNEL, 32'(lcg_state[31 -: `APG_NUM_SIG]), 0,
              "clear_double_wr");
      add_row(OP_READ, REG_READ_CHANNEL, 0, 32'(long_shot[0] ^ LOOP_MASK), "clear_pre_rd0");
      add_row(OP_READ, REG_READ_CHANNEL, 0, 32'(long_shot[1] ^ LOOP_MASK), "clear_pre_rd1");
      add_row(OP_READ, REG_WRITE_LEN, 0, 4, "clear_pre_len");
      add_row(OP_READ, REG_READ_PTR, 0, 3, "clear_pre_ptr");
      add_row(OP_READ, REG_DBG_ERROR, 0, 1, "clear_pre_dbg");
      add_row(OP_WRITE, REG_CLEAR, 1, 0, "clear_cmd");
      add_row(OP_READ, REG_WRITE_LEN, 0, 0, "clear_len");
      add_row(OP_READ, REG_DBG_ERROR, 0, 0, "clear_dbg");
      // Pointer first, a channel read moves it on
      add_row(OP_READ, REG_READ_PTR, 0, 1, "clear_ptr");
      add_row(OP_READ, REG_READ_CHANNEL, 0, 0, "clear_channel");
   endtask

   task automatic run_table();
      logic [31:0] value;
      for (int i = 0; i < op_q.size(); i++) begin
         case (op_q[i])
            OP_WRITE: reg_write(addr_q[i], data_q[i]);
            OP_DOUBLE_WRITE: reg_double_write(addr_q[i], data_q[i]);
            OP_READ: begin
               reg_read(addr_q[i], value);
               check_value(name_q[i], exp_q[i], value);
            end
            OP_WAIT: wait_state(exp_q[i][1:0], name_q[i]);
            default: check_output(exp_q[i], name_q[i]);
         endcase
      end
   endtask

   initial begin
      axi_resetn    = 1'b0;
      reg_wr        = 1'b0;
      reg_rd        = 1'b0;
      reg_addr      = REG_STATUS;
      reg_wdata     = '0;
      check_count   = 0;
      error_count   = 0;
      timeout_count = 0;
      exp_count     = '0;
      build_table();
      repeat (10) @(posedge axi_clk);
      axi_resetn <= 1'b1;
      // Wave reset release takes a few wave_clk cycles
      repeat (10) @(posedge axi_clk);
      run_table();
      $display("Checks %0d, mismatches %0d, timeouts %0d",
               check_count, error_count, timeout_count);
      if (error_count == 0 && timeout_count == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* flist.f */
+incdir+.
apg_state_pkg.sv
apg_reg_pkg.sv
bit_sync.sv
glitchless_state_cdc.sv
apg_reg_file.sv
arbitrary_pattern_generator.sv
apg_top.sv
apg_tb.sv

/* Makefile */
# Verilator flow for the pattern generator
TOP := apg_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module apg_top
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
